/* uart_axil_bridge.f */
rtl/bridge_pkg.sv
rtl/uart_rx.sv
rtl/byte_fifo.sv
rtl/frame_parser.sv
rtl/axil_master.sv
rtl/response_builder.sv
rtl/uart_tx.sv
rtl/uart_axil_bridge.sv
bench/tb_uart_axil_bridge.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_axil_bridge \
    -f uart_axil_bridge.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0

/* bench/tb_uart_axil_bridge.sv */
`timescale 1ns/1ps

module tb_uart_axil_bridge;

    localparam int BIT_CLKS   = 16;    // 10 MHz over 625 kBd
    localparam int RESP_LIMIT = 6000;  // Cycles to wait for response bytes
    localparam int IDLE_LIMIT = 3000;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        rx_line = 1'b1;
    logic        tx_line;
    logic        busy;
    logic [31:0] axi_awaddr, axi_wdata, axi_araddr;
    logic [3:0]  axi_wstrb;
    logic        axi_awvalid, axi_wvalid, axi_bready, axi_arvalid, axi_rready;
    logic        awready = 1'b0;
    logic        wready = 1'b0;
    logic        bvalid = 1'b0;
    logic        arready = 1'b0;
    logic        rvalid = 1'b0;
    logic [1:0]  bresp = 2'b00;
    logic [1:0]  rresp = 2'b00;
    logic [31:0] rdata = 32'h0;

    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    logic        bus_quiet = 1'b1;  // No AXI access allowed while set
    logic [31:0] lfsr = 32'h710e;
    logic [7:0]  rx_q[$];           // Bytes seen on the response line

    uart_axil_bridge #(
        .CLK_FREQ_HZ(10_000_000), .BAUD_RATE(625_000), .FIFO_DEPTH(16)
    ) u_uart_axil_bridge (
        .clk(clk), .rst(rst), .uart_rx(rx_line), .uart_tx(tx_line),
        .axi_awaddr(axi_awaddr), .axi_awvalid(axi_awvalid), .axi_awready(awready),
        .axi_wdata(axi_wdata), .axi_wstrb(axi_wstrb), .axi_wvalid(axi_wvalid),
        .axi_wready(wready), .axi_bresp(bresp), .axi_bvalid(bvalid),
        .axi_bready(axi_bready), .axi_araddr(axi_araddr), .axi_arvalid(axi_arvalid),
        .axi_arready(arready), .axi_rdata(rdata), .axi_rresp(rresp),
        .axi_rvalid(rvalid), .axi_rready(axi_rready), .busy(busy)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_delay(output logic [1:0] d);
        lfsr = lfsr_next(lfsr);
        d[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        d[1] = lfsr[0];
    endtask

    // AXI slave model with 16 words and SLVERR from 0x100 up
    logic [31:0] mem [16];
    logic [1:0]  aw_wait, w_wait, ar_wait;
    logic        aw_done, w_done, b_fire, r_fire;
    logic [31:0] wr_addr, wr_data, rd_addr;
    logic [3:0]  wr_strb;

    always @(negedge clk) begin
        if (rst) begin
            awready = 1'b0;
            wready  = 1'b0;
            arready = 1'b0;
            bvalid  = 1'b0;
            rvalid  = 1'b0;
            aw_done = 1'b0;
            w_done  = 1'b0;
            b_fire  = 1'b0;
            r_fire  = 1'b0;
            draw_delay(aw_wait);
            draw_delay(w_wait);
            draw_delay(ar_wait);
        end else begin
            if (b_fire) bvalid = 1'b0;
            if (r_fire) rvalid = 1'b0;
            // Readies only go high against a valid, so each one was a handshake
            if (awready) begin
                awready = 1'b0;
                aw_done = 1'b1;
            end
            if (wready) begin
                wready = 1'b0;
                w_done = 1'b1;
            end
            if (arready) begin
                arready = 1'b0;
                rvalid  = 1'b1;
            end
            if (aw_done && w_done) begin
                aw_done = 1'b0;
                w_done  = 1'b0;
                bresp   = (wr_addr >= 32'h100) ? 2'b10 : 2'b00;
                if (wr_addr < 32'h100) mem[wr_addr[5:2]] = wr_data;
                bvalid = 1'b1;
            end
            if (axi_awvalid && !aw_done) begin
                if (aw_wait == 2'd0) begin
                    awready = 1'b1;
                    wr_addr = axi_awaddr;
                    draw_delay(aw_wait);
                end else aw_wait = aw_wait - 1'b1;
            end
            if (axi_wvalid && !w_done) begin
                if (w_wait == 2'd0) begin
                    wready  = 1'b1;
                    wr_data = axi_wdata;
                    wr_strb = axi_wstrb;
                    draw_delay(w_wait);
                end else w_wait = w_wait - 1'b1;
            end
            if (axi_arvalid && !rvalid) begin
                if (ar_wait == 2'd0) begin
                    arready = 1'b1;
                    rd_addr = axi_araddr;
                    rresp   = (axi_araddr >= 32'h100) ? 2'b10 : 2'b00;
                    rdata   = (axi_araddr >= 32'h100) ? 32'h0 : mem[axi_araddr[5:2]];
                    draw_delay(ar_wait);
                end else ar_wait = ar_wait - 1'b1;
            end
            b_fire = bvalid && axi_bready;  // Taken at the coming posedge
            r_fire = rvalid && axi_rready;
        end
    end

    // Serial monitor samples mid-bit on the falling edge
    logic       mon_busy = 1'b0;
    int         mon_cnt, mon_bit;
    logic [7:0] mon_byte;

    always @(negedge clk) begin
        if (rst) begin
            mon_busy = 1'b0;
        end else if (!mon_busy) begin
            if (!tx_line) begin
                mon_busy = 1'b1;
                mon_cnt  = BIT_CLKS / 2;
                mon_bit  = 0;
            end
        end else begin
            mon_cnt = mon_cnt - 1;
            if (mon_cnt == 0) begin
                mon_cnt = BIT_CLKS;
                if (mon_bit == 0) begin
                    assert (!tx_line) else begin
                        errors++;
                        $display("[FAIL] %0t: start bit on the response line ended early",
                                 $time);
                    end
                    if (tx_line) mon_busy = 1'b0;
                end else if (mon_bit <= 8) begin
                    mon_byte = {tx_line, mon_byte[7:1]};
                end else begin
                    assert (tx_line) else begin
                        errors++;
                        $display("[FAIL] %0t: stop bit on the response line was low", $time);
                    end
                    rx_q.push_back(mon_byte);
                    mon_busy = 1'b0;
                end
                mon_bit++;
            end
        end
    end

    a_aw_stable: assert property (@(posedge clk) disable iff (rst)
        axi_awvalid && !awready |=> axi_awvalid && $stable(axi_awaddr))
        else begin
            errors++;
            $display("[FAIL] %0t: awvalid dropped or awaddr moved before awready", $time);
        end
    a_w_stable: assert property (@(posedge clk) disable iff (rst)
        axi_wvalid && !wready |=> axi_wvalid && $stable(axi_wdata) && $stable(axi_wstrb))
        else begin
            errors++;
            $display("[FAIL] %0t: wvalid dropped or write payload moved before wready", $time);
        end
    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        axi_arvalid && !arready |=> axi_arvalid && $stable(axi_araddr))
        else begin
            errors++;
            $display("[FAIL] %0t: arvalid dropped or araddr moved before arready", $time);
        end
    // The model offers a response beat only after the master asked for it
    a_resp_ready: assert property (@(posedge clk) disable iff (rst)
        (!bvalid || axi_bready) && (!rvalid || axi_rready))
        else begin
            errors++;
            $display("[FAIL] %0t: response beat offered while bready or rready was low",
                     $time);
        end
    a_bus_quiet: assert property (@(posedge clk) disable iff (rst)
        bus_quiet |-> !(axi_awvalid || axi_wvalid || axi_arvalid || axi_bready || axi_rready))
        else begin
            errors++;
            $display("[FAIL] %0t: AXI valid or ready raised while no access was expected",
                     $time);
        end
    a_tx_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> tx_line)
        else begin
            errors++;
            $display("[FAIL] %0t: uart_tx low while the bridge is idle", $time);
        end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout while waiting for %s at %0t", what, $time);
    endtask

    // Host sends one byte LSB first, starting on a falling edge
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] bits;
        int         i;
        bits = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            rx_line = bits[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
    endtask

    task automatic send_frame(input logic [7:0] cmd_b, input logic [31:0] addr_w,
                              input logic [31:0] data_w);
        int i;
        send_byte(cmd_b);
        for (i = 0; i < 4; i++) send_byte(addr_w[8*i +: 8]);
        if (!cmd_b[7]) begin
            for (i = 0; i < 4; i++) send_byte(data_w[8*i +: 8]);
        end
    endtask

    task automatic expect_response(input logic [7:0] status, input logic [7:0] cmd_b,
                                   input int n_data, input logic [31:0] data);
        int         cycles;
        int         i;
        logic [7:0] b;
        cycles = 0;
        while (rx_q.size() < 2 + n_data && cycles < RESP_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rx_q.size() < 2 + n_data) begin
            report_timeout("response bytes");
        end else begin
            b = rx_q.pop_front();
            check_value(32'(b), 32'(status), "status byte");
            b = rx_q.pop_front();
            check_value(32'(b), 32'(cmd_b), "command echo");
            for (i = 0; i < n_data; i++) begin
                b = rx_q.pop_front();
                check_value(32'(b), 32'(data[8*i +: 8]), "read data byte");
            end
        end
        @(negedge clk);
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (busy && cycles < IDLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (busy) report_timeout("the bridge to go idle");
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int mark);
        tests++;
        if (errors == mark) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: %0d errors", tests, name, errors - mark);
        end
    endtask

    initial begin
        int mark;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        mark = errors;
        repeat (40) @(negedge clk);
        check_value(32'(tx_line), 32'h1, "uart_tx after reset");
        check_value(32'(busy), 32'h0, "busy after reset");
        report_test("reset state", mark);

        mark = errors;
        bus_quiet = 1'b0;
        send_frame(8'h00, 32'h8, 32'hdeadbeef);
        expect_response(8'h00, 8'h00, 0, 32'h0);
        check_value(wr_addr, 32'h8, "awaddr");
        check_value(wr_data, 32'hdeadbeef, "wdata");
        check_value(32'(wr_strb), 32'hf, "wstrb");
        send_frame(8'h80, 32'h8, 32'h0);
        expect_response(8'h00, 8'h80, 4, 32'hdeadbeef);
        report_test("write then read", mark);

        mark = errors;
        send_frame(8'h80, 32'h104, 32'h0);
        expect_response(8'h03, 8'h80, 0, 32'h0);
        check_value(rd_addr, 32'h104, "araddr");
        wait_idle();
        check_value(rx_q.size(), 32'h0, "extra bytes after bus error");
        report_test("read bus error", mark);

        mark = errors;
        bus_quiet = 1'b1;
        send_byte(8'h41);
        expect_response(8'h02, 8'h41, 0, 32'h0);
        wait_idle();
        check_value(rx_q.size(), 32'h0, "extra bytes after bad command");
        bus_quiet = 1'b0;
        send_frame(8'h00, 32'h20, 32'h12345678);
        expect_response(8'h00, 8'h00, 0, 32'h0);
        report_test("bad command", mark);

        mark = errors;
        send_frame(8'h00, 32'h3c, 32'hc0ffee11);
        send_frame(8'h80, 32'h3c, 32'h0);
        send_frame(8'h00, 32'h200, 32'h5a5a5a5a);
        expect_response(8'h00, 8'h00, 0, 32'h0);
        expect_response(8'h00, 8'h80, 4, 32'hc0ffee11);
        expect_response(8'h03, 8'h00, 0, 32'h0);
        report_test("back to back frames", mark);

        $display("%0d tests, %0d failed, %0d failed checks", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* rtl/uart_axil_bridge.sv */
`timescale 1ns/1ps

module uart_axil_bridge import bridge_pkg::*; #(
    parameter int CLK_FREQ_HZ = 50_000_000,
    parameter int BAUD_RATE   = 115_200,
    parameter int FIFO_DEPTH  = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       uart_rx,
    output logic       uart_tx,
    output addr_t      axi_awaddr,
    output logic       axi_awvalid,
    input  logic       axi_awready,
    output word_t      axi_wdata,
    output logic [3:0] axi_wstrb,
    output logic       axi_wvalid,
    input  logic       axi_wready,
    input  resp_t      axi_bresp,
    input  logic       axi_bvalid,
    output logic       axi_bready,
    output addr_t      axi_araddr,
    output logic       axi_arvalid,
    input  logic       axi_arready,
    input  word_t      axi_rdata,
    input  resp_t      axi_rresp,
    input  logic       axi_rvalid,
    output logic       axi_rready,
    output logic       busy
);

    localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;

    byte_t   rx_byte;
    logic    rx_valid;
    logic    rx_active;
    byte_t   fifo_data;
    logic    fifo_empty;
    logic    fifo_rd_en;
    byte_t   cmd;
    addr_t   addr;
    word_t   wdata;
    logic    frame_valid;
    logic    frame_error;
    logic    frame_busy;
    logic    frame_done;
    logic    bus_done;
    status_t bus_status;
    word_t   rdata_out;
    byte_t   tx_byte;
    logic    tx_start;
    logic    tx_busy;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .clk(clk), .rst(rst), .rx(uart_rx),
        .rx_byte(rx_byte), .rx_valid(rx_valid), .rx_active(rx_active)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_byte_fifo (
        .clk(clk), .rst(rst), .wr_en(rx_valid), .wr_data(rx_byte),
        .rd_en(fifo_rd_en), .rd_data(fifo_data), .empty(fifo_empty), .full()
    );

    frame_parser u_frame_parser (
        .clk(clk), .rst(rst), .empty(fifo_empty), .rd_data(fifo_data),
        .rd_en(fifo_rd_en), .frame_done(frame_done), .cmd(cmd), .addr(addr),
        .wdata(wdata), .frame_valid(frame_valid), .frame_error(frame_error),
        .frame_busy(frame_busy)
    );

    axil_master u_axil_master (
        .clk(clk), .rst(rst), .frame_valid(frame_valid), .cmd(cmd),
        .addr(addr), .wdata(wdata),
        .axi_awaddr(axi_awaddr), .axi_awvalid(axi_awvalid), .axi_awready(axi_awready),
        .axi_wdata(axi_wdata), .axi_wstrb(axi_wstrb), .axi_wvalid(axi_wvalid),
        .axi_wready(axi_wready), .axi_bresp(axi_bresp), .axi_bvalid(axi_bvalid),
        .axi_bready(axi_bready), .axi_araddr(axi_araddr), .axi_arvalid(axi_arvalid),
        .axi_arready(axi_arready), .axi_rdata(axi_rdata), .axi_rresp(axi_rresp),
        .axi_rvalid(axi_rvalid), .axi_rready(axi_rready),
        .bus_done(bus_done), .bus_status(bus_status), .rdata_out(rdata_out)
    );

    response_builder u_response_builder (
        .clk(clk), .rst(rst), .bus_done(bus_done), .frame_error(frame_error),
        .cmd(cmd), .bus_status(bus_status), .rdata_out(rdata_out),
        .tx_busy(tx_busy), .tx_byte(tx_byte), .tx_start(tx_start),
        .frame_done(frame_done)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .clk(clk), .rst(rst), .tx_start(tx_start), .tx_byte(tx_byte),
        .tx(uart_tx), .tx_busy(tx_busy)
    );

    assign busy = frame_busy || rx_active || tx_busy;

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx import bridge_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  tx_start,
    input  byte_t tx_byte,
    output logic  tx,
    output logic  tx_busy
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    logic [9:0]    shift;     // Stop, data LSB first, start
    logic [3:0]    bit_cnt;
    logic [CW-1:0] baud_cnt;

    assign tx = shift[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            shift    <= '1;
            bit_cnt  <= '0;
            baud_cnt <= '0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                shift    <= {1'b1, tx_byte, 1'b0};
                bit_cnt  <= '0;
                baud_cnt <= '0;
                tx_busy  <= 1'b1;
            end
        end else if (baud_cnt == CW'(CLKS_PER_BIT - 1)) begin
            baud_cnt <= '0;
            shift    <= {1'b1, shift[9:1]}; // Refill with idle level
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) tx_busy <= 1'b0; // End of stop bit
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

/* rtl/response_builder.sv */
`timescale 1ns/1ps

module response_builder import bridge_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    bus_done,
    input  logic    frame_error,
    input  byte_t   cmd,
    input  status_t bus_status,
    input  word_t   rdata_out,
    input  logic    tx_busy,
    output byte_t   tx_byte,
    output logic    tx_start,
    output logic    frame_done
);

    typedef enum logic {B_IDLE, B_SEND} bld_state_t;

    bld_state_t state;
    status_t    status_q;
    logic [2:0] idx;
    logic [2:0] last_idx;
    byte_t      byte_sel;

    // Status and echo always, data only for a good read
    assign last_idx = (cmd[CMD_READ_BIT] && status_q == STATUS_OK) ?
                      3'(WORD_BYTES + 1) : 3'd1;

    always_comb begin
        case (idx)
            3'd0:    byte_sel = status_q;
            3'd1:    byte_sel = cmd;
            default: byte_sel = rdata_out[8 * (idx - 3'd2) +: 8];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= B_IDLE;
            status_q   <= STATUS_OK;
            idx        <= '0;
            tx_start   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            tx_start   <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                B_IDLE: begin
                    idx <= '0;
                    if (bus_done || frame_error) begin
                        status_q <= frame_error ? STATUS_BAD_CMD : bus_status;
                        state    <= B_SEND;
                    end
                end
                B_SEND: begin
                    // tx_busy lags tx_start by a cycle, so skip that cycle
                    if (!tx_busy && !tx_start) begin
                        tx_start <= 1'b1;
                        tx_byte  <= byte_sel;
                        idx      <= idx + 1'b1;
                        if (idx == last_idx) begin
                            frame_done <= 1'b1;
                            state      <= B_IDLE;
                        end
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !tx_busy);

endmodule

/* rtl/axil_master.sv */
`timescale 1ns/1ps

module axil_master import bridge_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    frame_valid,
    input  byte_t   cmd,
    input  addr_t   addr,
    input  word_t   wdata,
    output addr_t   axi_awaddr,
    output logic    axi_awvalid,
    input  logic    axi_awready,
    output word_t   axi_wdata,
    output logic [3:0] axi_wstrb,
    output logic    axi_wvalid,
    input  logic    axi_wready,
    input  resp_t   axi_bresp,
    input  logic    axi_bvalid,
    output logic    axi_bready,
    output addr_t   axi_araddr,
    output logic    axi_arvalid,
    input  logic    axi_arready,
    input  word_t   axi_rdata,
    input  resp_t   axi_rresp,
    input  logic    axi_rvalid,
    output logic    axi_rready,
    output logic    bus_done,
    output status_t bus_status,
    output word_t   rdata_out
);

    typedef enum logic [2:0] {M_IDLE, M_WRITE, M_BRESP, M_AR, M_RDATA} mst_state_t;

    mst_state_t state;

    function automatic status_t status_of(resp_t r);
        return (r == 2'b00) ? STATUS_OK : STATUS_BUS_ERR; // Only OKAY passes
    endfunction

    assign axi_wstrb = {WORD_BYTES{1'b1}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= M_IDLE;
            axi_awvalid <= 1'b0;
            axi_wvalid  <= 1'b0;
            axi_bready  <= 1'b0;
            axi_arvalid <= 1'b0;
            axi_rready  <= 1'b0;
            bus_done    <= 1'b0;
            bus_status  <= STATUS_OK;
        end else begin
            bus_done <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (frame_valid && cmd[CMD_READ_BIT]) begin
                        axi_araddr  <= addr;
                        axi_arvalid <= 1'b1;
                        state       <= M_AR;
                    end else if (frame_valid) begin
                        axi_awaddr  <= addr;
                        axi_wdata   <= wdata;
                        axi_awvalid <= 1'b1;
                        axi_wvalid  <= 1'b1;
                        state       <= M_WRITE;
                    end
                end
                M_WRITE: begin
                    // Each valid is its own "still pending" flag
                    if (axi_awready) axi_awvalid <= 1'b0;
                    if (axi_wready) axi_wvalid <= 1'b0;
                    if ((axi_awready || !axi_awvalid) && (axi_wready || !axi_wvalid)) begin
                        axi_bready <= 1'b1;
                        state      <= M_BRESP;
                    end
                end
                M_BRESP: begin
                    if (axi_bvalid) begin
                        axi_bready <= 1'b0;
                        bus_status <= status_of(axi_bresp);
                        bus_done   <= 1'b1;
                        state      <= M_IDLE;
                    end
                end
                M_AR: begin
                    if (axi_arready) begin
                        axi_arvalid <= 1'b0;
                        axi_rready  <= 1'b1;
                        state       <= M_RDATA;
                    end
                end
                M_RDATA: begin
                    if (axi_rvalid) begin
                        axi_rready <= 1'b0;
                        rdata_out  <= axi_rdata;
                        bus_status <= status_of(axi_rresp);
                        bus_done   <= 1'b1;
                        state      <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr));

endmodule

/* rtl/frame_parser.sv */
`timescale 1ns/1ps

module frame_parser import bridge_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  empty,
    input  byte_t rd_data,
    output logic  rd_en,
    input  logic  frame_done,
    output byte_t cmd,
    output addr_t addr,
    output word_t wdata,
    output logic  frame_valid,
    output logic  frame_error,
    output logic  frame_busy
);

    localparam int    CNT_W     = $clog2(WORD_BYTES);
    localparam byte_t RSVD_MASK = ~(byte_t'(1) << CMD_READ_BIT);

    typedef enum logic [1:0] {P_CMD, P_ADDR, P_DATA, P_HOLD} parse_state_t;

    parse_state_t     state;
    logic [CNT_W-1:0] byte_cnt;

    // Pop whenever a byte waits, except while a frame is held
    assign rd_en      = !empty && (state != P_HOLD);
    assign frame_busy = (state != P_CMD);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= P_CMD;
            byte_cnt    <= '0;
            frame_valid <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            frame_error <= 1'b0;
            case (state)
                P_CMD: begin
                    byte_cnt <= '0;
                    if (rd_en) begin
                        cmd <= rd_data;
                        if ((rd_data & RSVD_MASK) != '0) begin
                            frame_error <= 1'b1; // Rest of the frame stays unread
                            state       <= P_HOLD;
                        end else begin
                            state <= P_ADDR;
                        end
                    end
                end
                P_ADDR: begin
                    if (rd_en) begin
                        addr     <= {rd_data, addr[31:8]};
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == CNT_W'(WORD_BYTES - 1)) begin
                            if (cmd[CMD_READ_BIT]) begin
                                frame_valid <= 1'b1;
                                state       <= P_HOLD;
                            end else begin
                                state <= P_DATA;
                            end
                        end
                    end
                end
                P_DATA: begin
                    if (rd_en) begin
                        wdata    <= {rd_data, wdata[31:8]};
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == CNT_W'(WORD_BYTES - 1)) begin
                            frame_valid <= 1'b1;
                            state       <= P_HOLD;
                        end
                    end
                end
                P_HOLD: if (frame_done) state <= P_CMD; // Response fully started
                default: state <= P_CMD;
            endcase
        end
    end

endmodule

/* rtl/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo import bridge_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  wr_en,
    input  byte_t wr_data,
    input  logic  rd_en,
    output byte_t rd_data,
    output logic  empty,
    output logic  full
);

    localparam int AW = $clog2(FIFO_DEPTH);

    byte_t        mem [FIFO_DEPTH];
    logic [AW:0]  wr_ptr;   // MSB is the wrap bit
    logic [AW:0]  rd_ptr;

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign rd_data = mem[rd_ptr[AW-1:0]]; // Head shown ahead

    always_ff @(posedge clk) begin
        if (wr_en && !full) mem[wr_ptr[AW-1:0]] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en && !full) wr_ptr <= wr_ptr + 1'b1; // Full drops the byte
            if (rd_en && !empty) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> !empty);

endmodule

/* rtl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx import bridge_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  rx,
    output byte_t rx_byte,
    output logic  rx_valid,
    output logic  rx_active
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t       state;
    logic [CW-1:0]   clk_cnt;
    logic [2:0]      bit_idx;
    logic            rx_meta;
    logic            rx_s;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_s) state <= RX_START;
                end
                RX_START: begin
                    // Half a bit in, the start bit must still be low
                    if (clk_cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        rx_byte <= {rx_s, rx_byte[7:1]}; // LSB arrives first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
                        rx_valid <= rx_s; // Framing error drops the byte
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    assign rx_active = (state != RX_IDLE);

    a_rx_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid);

endmodule

/* rtl/bridge_pkg.sv */
package bridge_pkg;

    // Widths with a meaning on the serial and bus sides
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [1:0]  resp_t;
    typedef logic [7:0]  status_t;

    // Response status byte
    localparam status_t STATUS_OK      = 8'h00;
    localparam status_t STATUS_BAD_CMD = 8'h02; // Reserved command bits set
    localparam status_t STATUS_BUS_ERR = 8'h03; // SLVERR or DECERR from the bus

    // Frame layout
    localparam int CMD_READ_BIT = 7;
    localparam int WORD_BYTES   = 4; // Address and data bytes, LSB first

endpackage
